/* Makefile */
TOP := osd_i2c_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f compile.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Result: PASSED" sim.log

lint:
	verilator --lint-only -Wall --timing -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

/* compile.f */
+incdir+include
logic/i2c_pkg.sv
logic/osd_pkg.sv
logic/i2c_byte_slave.sv
logic/ctrl_regs.sv
logic/osd_ram.sv
logic/reg_dispatch.sv
logic/osd_i2c_top.sv
test/osd_i2c_chk.sv
test/osd_i2c_tb.sv

/* include/osd_cfg.svh */
// Shared sizes and addresses of the OSD character memory, included by packages and RTL
`ifndef OSD_CFG_SVH
`define OSD_CFG_SVH

////////////////////////////////////////////////////////////
// I2C slave identity
////////////////////////////////////////////////////////////

// Seven-bit slave address matched against the first byte after START
`define OSD_I2C_DEV_ADDR 7'h3c

////////////////////////////////////////////////////////////
// Character RAM geometry
////////////////////////////////////////////////////////////

// 1024 cells, addressed as page above column
`define OSD_RAM_DEPTH 1024
`define OSD_RAM_AW 10
`define OSD_PAGE_W 3
// Column offset inside the 128-byte bus window
`define OSD_COL_W 7

////////////////////////////////////////////////////////////
// Control space register indices (address bit 7 set)
////////////////////////////////////////////////////////////

`define OSD_REG_PAGE 1'b0
`define OSD_REG_CTRL 1'b1

`endif

/* logic/ctrl_regs.sv */
// Page and display-control registers written and read back through the dispatcher strobes
`timescale 1ns/1ps
`include "osd_cfg.svh"

module ctrl_regs (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   ctrl_wr,
  input  logic                   ctrl_rd,
  input  logic                   ctrl_idx,
  input  logic [7:0]             ctrl_wdata,
  output logic [`OSD_PAGE_W-1:0] page,
  output logic                   enable_osd,
  output logic [7:0]             ctrl_rdata
);

  osd_pkg::osd_ctrl_t ctrl_q;

  ////////////////////////////////////////////////////////////
  // Register writes
  ////////////////////////////////////////////////////////////

  // Page selects which 128-byte slice of the RAM the window maps to
  // Only bit 0 of a ctrl write matters, it turns the display on or off
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ctrl_q <= '0;
    end else if (ctrl_wr) begin
      if (ctrl_idx == `OSD_REG_PAGE) begin
        ctrl_q.page <= ctrl_wdata[`OSD_PAGE_W-1:0];
      end else if (ctrl_idx == `OSD_REG_CTRL) begin
        ctrl_q.enable <= ctrl_wdata[0];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Readback
  ////////////////////////////////////////////////////////////

  // Data appears one cycle after the read strobe and holds until the next one
  always_ff @(posedge clk) begin
    if (ctrl_rd) begin
      if (ctrl_idx == `OSD_REG_PAGE) begin
        ctrl_rdata <= {{(8 - `OSD_PAGE_W){1'b0}}, ctrl_q.page};
      end else begin
        ctrl_rdata <= {7'd0, ctrl_q.enable};
      end
    end
  end

  assign page       = ctrl_q.page;
  assign enable_osd = ctrl_q.enable;

endmodule

/* logic/i2c_byte_slave.sv */
// I2C slave byte engine that turns bus transfers into register accesses for the dispatcher
`timescale 1ns/1ps
`include "osd_cfg.svh"

module i2c_byte_slave (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                scl,
  input  logic                sda_in,
  input  logic                acc_ack,
  input  i2c_pkg::reg_resp_t  resp,
  output logic                sda_oe,
  output logic                acc_req,
  output i2c_pkg::reg_access_t acc
);

  // Bit-level states of the slave
  localparam logic [2:0] S_IDLE = 3'd0;
  localparam logic [2:0] S_ADDR = 3'd1;
  localparam logic [2:0] S_RX   = 3'd2;
  localparam logic [2:0] S_ACK  = 3'd3;
  localparam logic [2:0] S_TX   = 3'd4;
  localparam logic [2:0] S_MACK = 3'd5;

  logic [2:0] scl_sync;
  logic [2:0] sda_sync;
  logic [2:0] state;
  logic [3:0] bit_cnt;
  logic [7:0] shreg;
  logic [7:0] reg_addr;
  logic       rw;
  logic       first_byte;
  logic       scl_rise;
  logic       scl_fall;
  logic       start_det;
  logic       stop_det;

  ////////////////////////////////////////////////////////////
  // Bus sampling and condition detection
  ////////////////////////////////////////////////////////////

  // Bits 1 and 2 of each shifter are the current and previous synchronized values
  assign scl_rise  = scl_sync[1] & ~scl_sync[2];
  assign scl_fall  = ~scl_sync[1] & scl_sync[2];
  // START and STOP are SDA edges while SCL stays high
  assign start_det = scl_sync[1] & scl_sync[2] & sda_sync[2] & ~sda_sync[1];
  assign stop_det  = scl_sync[1] & scl_sync[2] & ~sda_sync[2] & sda_sync[1];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      scl_sync   <= 3'b111;
      sda_sync   <= 3'b111;
      state      <= S_IDLE;
      bit_cnt    <= 4'd0;
      sda_oe     <= 1'b0;
      acc_req    <= 1'b0;
      rw         <= 1'b0;
      first_byte <= 1'b0;
      reg_addr   <= 8'd0;
    end else begin
      scl_sync <= {scl_sync[1:0], scl};
      sda_sync <= {sda_sync[1:0], sda_in};

      // Close the handshake, a read result becomes the next byte to shift out
      // The register address advances once per completed access
      if (acc_req && acc_ack) begin
        acc_req  <= 1'b0;
        reg_addr <= reg_addr + 8'd1;
        if (!acc.wr) begin
          shreg <= resp.rdata;
        end
      end

      if (start_det) begin
        // Also covers a repeated START in the middle of a transfer
        state   <= S_ADDR;
        bit_cnt <= 4'd0;
        sda_oe  <= 1'b0;
      end else if (stop_det) begin
        state  <= S_IDLE;
        sda_oe <= 1'b0;
      end else begin
        case (state)
          S_ADDR, S_RX: begin
            if (scl_rise && bit_cnt != 4'd8) begin
              shreg   <= {shreg[6:0], sda_sync[1]};
              bit_cnt <= bit_cnt + 4'd1;
            end else if (scl_fall && bit_cnt == 4'd8) begin
              bit_cnt <= 4'd0;
              if (state == S_ADDR) begin
                // Without a match the slave stays silent until the next START
                if (shreg[7:1] == `OSD_I2C_DEV_ADDR) begin
                  sda_oe     <= 1'b1;
                  rw         <= shreg[0];
                  first_byte <= ~shreg[0];
                  state      <= S_ACK;
                  // Fetch the first read byte while the ACK is on the bus
                  if (shreg[0]) begin
                    acc_req    <= 1'b1;
                    acc.addr   <= reg_addr;
                    acc.wdata  <= 8'h00;
                    acc.wr     <= 1'b0;
                  end
                end else begin
                  state <= S_IDLE;
                end
              end else begin
                sda_oe <= 1'b1;
                state  <= S_ACK;
                // The first written byte only loads the register address
                if (first_byte) begin
                  reg_addr   <= shreg;
                  first_byte <= 1'b0;
                end else begin
                  acc_req   <= 1'b1;
                  acc.addr  <= reg_addr;
                  acc.wdata <= shreg;
                  acc.wr    <= 1'b1;
                end
              end
            end
          end
          S_ACK: begin
            if (scl_fall) begin
              if (rw) begin
                // Put the MSB of the fetched byte on the bus
                sda_oe  <= ~shreg[7];
                bit_cnt <= 4'd1;
                state   <= S_TX;
              end else begin
                sda_oe <= 1'b0;
                state  <= S_RX;
              end
            end
          end
          S_TX: begin
            if (scl_fall) begin
              if (bit_cnt == 4'd8) begin
                sda_oe  <= 1'b0;
                bit_cnt <= 4'd0;
                state   <= S_MACK;
              end else begin
                sda_oe  <= ~shreg[6];
                shreg   <= {shreg[6:0], 1'b0};
                bit_cnt <= bit_cnt + 4'd1;
              end
            end
          end
          S_MACK: begin
            if (scl_rise) begin
              // NACK ends the read, an ACK prefetches the next byte
              if (sda_sync[1]) begin
                state <= S_IDLE;
              end else begin
                acc_req   <= 1'b1;
                acc.addr  <= reg_addr;
                acc.wdata <= 8'h00;
                acc.wr    <= 1'b0;
              end
            end else if (scl_fall) begin
              sda_oe  <= ~shreg[7];
              bit_cnt <= 4'd1;
              state   <= S_TX;
            end
          end
          default: ;
        endcase
      end
    end
  end

endmodule

/* logic/i2c_pkg.sv */
// Bus-side types passed between the I2C byte engine and the register dispatcher
package i2c_pkg;

  ////////////////////////////////////////////////////////////
  // Register access request
  ////////////////////////////////////////////////////////////

  // One register access, held stable while acc_req is high
  // The address is the raw 8-bit register address from the master
  // Write data is only meaningful when wr is set
  typedef struct packed {
    logic [7:0] addr;
    logic [7:0] wdata;
    logic       wr;
  } reg_access_t;

  ////////////////////////////////////////////////////////////
  // Register access response
  ////////////////////////////////////////////////////////////

  // Read data returned with acc_ack
  // On a write access the value carries no meaning
  typedef struct packed {
    logic [7:0] rdata;
  } reg_resp_t;

endpackage

/* logic/osd_i2c_top.sv */
// Top level of the OSD character memory, I2C slave in front of control registers and RAM
`timescale 1ns/1ps
`include "osd_cfg.svh"

module osd_i2c_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   scl,
  input  logic                   sda_in,
  input  logic [`OSD_RAM_AW-1:0] disp_addr,
  output logic                   sda_oe,
  output logic [7:0]             disp_data,
  output logic                   enable_osd
);

  ////////////////////////////////////////////////////////////
  // Interconnect
  ////////////////////////////////////////////////////////////

  // Handshake between the byte engine and the dispatcher
  logic                   acc_req;
  logic                   acc_ack;
  i2c_pkg::reg_access_t   acc;
  i2c_pkg::reg_resp_t     resp;
  // Strobes toward the control registers
  logic                   ctrl_wr;
  logic                   ctrl_rd;
  logic                   ctrl_idx;
  logic [7:0]             ctrl_wdata;
  logic [7:0]             ctrl_rdata;
  logic [`OSD_PAGE_W-1:0] page;
  // Strobes toward the RAM
  logic                   ram_we;
  osd_pkg::ram_wr_t       ram_wr;
  logic                   ram_rd;
  logic [`OSD_RAM_AW-1:0] ram_raddr;
  logic [7:0]             ram_rdata;

  i2c_byte_slave u_slave (
    .clk     (clk),
    .rst_n   (rst_n),
    .scl     (scl),
    .sda_in  (sda_in),
    .acc_ack (acc_ack),
    .resp    (resp),
    .sda_oe  (sda_oe),
    .acc_req (acc_req),
    .acc     (acc)
  );

  reg_dispatch u_dispatch (
    .clk        (clk),
    .rst_n      (rst_n),
    .acc_req    (acc_req),
    .acc        (acc),
    .page       (page),
    .ctrl_rdata (ctrl_rdata),
    .ram_rdata  (ram_rdata),
    .acc_ack    (acc_ack),
    .resp       (resp),
    .ctrl_wr    (ctrl_wr),
    .ctrl_rd    (ctrl_rd),
    .ctrl_idx   (ctrl_idx),
    .ctrl_wdata (ctrl_wdata),
    .ram_we     (ram_we),
    .ram_wr     (ram_wr),
    .ram_rd     (ram_rd),
    .ram_raddr  (ram_raddr)
  );

  ctrl_regs u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .ctrl_wr    (ctrl_wr),
    .ctrl_rd    (ctrl_rd),
    .ctrl_idx   (ctrl_idx),
    .ctrl_wdata (ctrl_wdata),
    .page       (page),
    .enable_osd (enable_osd),
    .ctrl_rdata (ctrl_rdata)
  );

  osd_ram u_ram (
    .clk       (clk),
    .ram_we    (ram_we),
    .ram_wr    (ram_wr),
    .ram_rd    (ram_rd),
    .ram_raddr (ram_raddr),
    .disp_addr (disp_addr),
    .ram_rdata (ram_rdata),
    .disp_data (disp_data)
  );

endmodule

/* logic/osd_pkg.sv */
// Display-side types: register address views, RAM write port and control state
package osd_pkg;

`include "osd_cfg.svh"

  ////////////////////////////////////////////////////////////
  // Register address decoding
  ////////////////////////////////////////////////////////////

  // Window view, a column inside the currently selected page
  typedef struct packed {
    logic                  ctrl_sel;
    logic [`OSD_COL_W-1:0] col;
  } win_view_t;

  // Control view, only the lowest bit picks the register
  typedef struct packed {
    logic       ctrl_sel;
    logic [5:0] rsvd;
    logic       idx;
  } ctrl_view_t;

  // Both views share bit 7 as the select, set means control space
  typedef union packed {
    win_view_t  win;
    ctrl_view_t ctrl;
  } reg_addr_u;

  ////////////////////////////////////////////////////////////
  // RAM write port
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [`OSD_RAM_AW-1:0] addr;
    logic [7:0]             data;
  } ram_wr_t;

  // Page register and display enable, as held by the control block
  typedef struct packed {
    logic [`OSD_PAGE_W-1:0] page;
    logic                   enable;
  } osd_ctrl_t;

endpackage

/* logic/osd_ram.sv */
// Character RAM with a bus write and readback port plus a separate display read port
`timescale 1ns/1ps
`include "osd_cfg.svh"

module osd_ram (
  input  logic                   clk,
  input  logic                   ram_we,
  input  osd_pkg::ram_wr_t       ram_wr,
  input  logic                   ram_rd,
  input  logic [`OSD_RAM_AW-1:0] ram_raddr,
  input  logic [`OSD_RAM_AW-1:0] disp_addr,
  output logic [7:0]             ram_rdata,
  output logic [7:0]             disp_data
);

  // One byte per character cell
  logic [7:0] mem [`OSD_RAM_DEPTH];

  ////////////////////////////////////////////////////////////
  // Bus port
  ////////////////////////////////////////////////////////////

  // Writes come only from the dispatcher
  always_ff @(posedge clk) begin
    if (ram_we) begin
      mem[ram_wr.addr] <= ram_wr.data;
    end
  end

  // Readback data is held between read strobes
  always_ff @(posedge clk) begin
    if (ram_rd) begin
      ram_rdata <= mem[ram_raddr];
    end
  end

  ////////////////////////////////////////////////////////////
  // Display port
  ////////////////////////////////////////////////////////////

  // The display engine reads every cycle, data follows the address by one clock
  always_ff @(posedge clk) begin
    disp_data <= mem[disp_addr];
  end

endmodule

/* logic/reg_dispatch.sv */
// Routes each register access to the control registers or the RAM and returns the result
`timescale 1ns/1ps
`include "osd_cfg.svh"

module reg_dispatch (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   acc_req,
  input  i2c_pkg::reg_access_t   acc,
  input  logic [`OSD_PAGE_W-1:0] page,
  input  logic [7:0]             ctrl_rdata,
  input  logic [7:0]             ram_rdata,
  output logic                   acc_ack,
  output i2c_pkg::reg_resp_t     resp,
  output logic                   ctrl_wr,
  output logic                   ctrl_rd,
  output logic                   ctrl_idx,
  output logic [7:0]             ctrl_wdata,
  output logic                   ram_we,
  output osd_pkg::ram_wr_t       ram_wr,
  output logic                   ram_rd,
  output logic [`OSD_RAM_AW-1:0] ram_raddr
);

  osd_pkg::reg_addr_u addr_u;
  logic               pending;
  logic               sel_q;

  // Same byte, read either as a window column or as a control index
  assign addr_u = acc.addr;

  ////////////////////////////////////////////////////////////
  // Strobe and handshake sequencing
  ////////////////////////////////////////////////////////////

  // Cycle 1 issues the strobe, cycle 2 raises ack with the part's data
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pending <= 1'b0;
      acc_ack <= 1'b0;
      ctrl_wr <= 1'b0;
      ctrl_rd <= 1'b0;
      ram_we  <= 1'b0;
      ram_rd  <= 1'b0;
    end else begin
      ctrl_wr <= 1'b0;
      ctrl_rd <= 1'b0;
      ram_we  <= 1'b0;
      ram_rd  <= 1'b0;
      if (acc_req && !acc_ack && !pending) begin
        pending <= 1'b1;
        if (addr_u.win.ctrl_sel) begin
          ctrl_wr <= acc.wr;
          ctrl_rd <= ~acc.wr;
        end else begin
          ram_we <= acc.wr;
          ram_rd <= ~acc.wr;
        end
      end
      if (pending) begin
        pending <= 1'b0;
        acc_ack <= 1'b1;
      end
      // Ack follows the falling request one cycle later
      if (!acc_req && acc_ack) begin
        acc_ack <= 1'b0;
      end
    end
  end

  // Addresses and data for the strobed part, RAM address is page above column
  always_ff @(posedge clk) begin
    if (acc_req && !acc_ack && !pending) begin
      sel_q       <= addr_u.win.ctrl_sel;
      ctrl_idx    <= addr_u.ctrl.idx;
      ctrl_wdata  <= acc.wdata;
      ram_wr.addr <= {page, addr_u.win.col};
      ram_wr.data <= acc.wdata;
      ram_raddr   <= {page, addr_u.win.col};
    end
  end

  // Pick the data of the part that the registered select points at
  assign resp.rdata = sel_q ? ctrl_rdata : ram_rdata;

endmodule

/* test/osd_i2c_chk.sv */
// Concurrent checks on the dispatcher handshake and part strobes, bound into reg_dispatch
`timescale 1ns/1ps

module osd_i2c_chk (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 acc_req,
  input i2c_pkg::reg_access_t acc,
  input logic                 acc_ack,
  input logic                 ctrl_wr,
  input logic                 ram_we
);

  ////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////

  // The request word is frozen for as long as acc_req stays high
  acc_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (acc_req && $past(acc_req)) |-> $stable(acc))
    else $error("acc changed while acc_req was high");

  // An ack only ever answers a pending request
  ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(acc_ack) |-> acc_req)
    else $error("acc_ack rose without acc_req");

  ////////////////////////////////////////////////////////////
  // Part strobes
  ////////////////////////////////////////////////////////////

  // One access goes to exactly one part
  one_writer: assert property (@(posedge clk) disable iff (!rst_n)
    !(ctrl_wr && ram_we))
    else $error("ctrl_wr and ram_we were high together");

endmodule

/* test/osd_i2c_tb.sv */
// Testbench for the OSD character memory, bit-bangs an I2C master and checks against a model
`timescale 1ns/1ps
`include "osd_cfg.svh"

module osd_i2c_tb;

  // Eight clk per SCL half period
  localparam int half_clks   = 8;
  localparam int max_trans   = 40;
  localparam int max_bytes   = 12;
  // Transactions times bytes times 9 bits times 16 clk, doubled for margin
  localparam int cycle_limit = max_trans * max_bytes * 9 * 16 * 2;

  logic                   clk;
  logic                   rst_n;
  logic                   scl;
  logic                   sda_drv;
  logic                   sda_line;
  logic [`OSD_RAM_AW-1:0] disp_addr;
  logic                   sda_oe;
  logic [7:0]             disp_data;
  logic                   enable_osd;

  // Reference model of the RAM, the control state and the register pointer
  logic [7:0]             mem_m [`OSD_RAM_DEPTH];
  logic                   written [`OSD_RAM_DEPTH];
  osd_pkg::osd_ctrl_t     ctrl_m;
  logic [7:0]             addr_m;
  logic [7:0]             wr_q [$];
  logic [`OSD_RAM_AW-1:0] touched_q [$];

  int data_errs = 0;
  int ctrl_errs = 0;
  int bus_errs  = 0;
  int cycles    = 0;

  // Open-drain bus, either side pulls SDA low
  assign sda_line = sda_drv & ~sda_oe;

  osd_i2c_top dut0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .scl        (scl),
    .sda_in     (sda_line),
    .disp_addr  (disp_addr),
    .sda_oe     (sda_oe),
    .disp_data  (disp_data),
    .enable_osd (enable_osd)
  );

  bind reg_dispatch osd_i2c_chk chk0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .acc_req (acc_req),
    .acc     (acc),
    .acc_ack (acc_ack),
    .ctrl_wr (ctrl_wr),
    .ram_we  (ram_we)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Result: FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_byte(input string name, input i2c_pkg::reg_resp_t got,
                            input i2c_pkg::reg_resp_t exp);
    if (got !== exp) begin
      data_errs++;
      $display("** Error at %0t: %s got %h expected %h", $time, name, got.rdata, exp.rdata);
    end
  endtask

  // Only the enable leaves the DUT as a pin, the page is checked by readback
  task automatic check_ctrl(input osd_pkg::osd_ctrl_t exp);
    @(negedge clk);
    if (enable_osd !== exp.enable) begin
      ctrl_errs++;
      $display("** Error at %0t: enable_osd got %b expected %b", $time, enable_osd, exp.enable);
    end
  endtask

  task automatic expect_ack(input logic ack, input string what);
    if (!ack) begin
      bus_errs++;
      $display("The DUT did not acknowledge the %s at %0t", what, $time);
    end
  endtask

  // Display port returns the cell one clock after the address
  task automatic check_display(input logic [`OSD_RAM_AW-1:0] a);
    i2c_pkg::reg_resp_t got;
    i2c_pkg::reg_resp_t exp;
    @(posedge clk);
    disp_addr <= a;
    @(posedge clk);
    @(negedge clk);
    got.rdata = disp_data;
    exp.rdata = mem_m[a];
    check_byte("disp_data", got, exp);
  endtask

  ////////////////////////////////////////////////////////////
  // Register model
  ////////////////////////////////////////////////////////////

  // Bit 7 picks control space, bit 0 the register, otherwise a column of the page
  function automatic void model_write(input logic [7:0] d);
    logic [`OSD_RAM_AW-1:0] a;
    a = {ctrl_m.page, addr_m[6:0]};
    if (addr_m[7]) begin
      if (addr_m[0]) begin
        ctrl_m.enable = d[0];
      end else begin
        ctrl_m.page = d[`OSD_PAGE_W-1:0];
      end
    end else begin
      mem_m[a]   = d;
      written[a] = 1'b1;
      touched_q.push_back(a);
    end
    addr_m = addr_m + 8'd1;
  endfunction

  function automatic logic [7:0] model_read();
    logic [7:0] v;
    if (addr_m[7]) begin
      if (addr_m[0]) begin
        v = {7'd0, ctrl_m.enable};
      end else begin
        v = {{(8 - `OSD_PAGE_W){1'b0}}, ctrl_m.page};
      end
    end else begin
      v = mem_m[{ctrl_m.page, addr_m[6:0]}];
    end
    addr_m = addr_m + 8'd1;
    return v;
  endfunction

  ////////////////////////////////////////////////////////////
  // I2C master
  ////////////////////////////////////////////////////////////

  task automatic wait_clks(input int n);
    repeat (n) @(posedge clk);
  endtask

  // SDA changes only in the middle of the SCL low phase
  task automatic clock_bit(input logic b, output logic sampled);
    wait_clks(half_clks / 2);
    sda_drv <= b;
    wait_clks(half_clks / 2);
    scl <= 1'b1;
    wait_clks(half_clks / 2);
    @(negedge clk);
    sampled = sda_line;
    wait_clks(half_clks / 2);
    scl <= 1'b0;
  endtask

  // Works from idle and as a repeated START after an ACK bit
  task automatic send_start();
    wait_clks(half_clks / 2);
    sda_drv <= 1'b1;
    wait_clks(half_clks / 2);
    scl <= 1'b1;
    wait_clks(half_clks);
    sda_drv <= 1'b0;
    wait_clks(half_clks);
    scl <= 1'b0;
  endtask

  task automatic send_stop();
    wait_clks(half_clks / 2);
    sda_drv <= 1'b0;
    wait_clks(half_clks / 2);
    scl <= 1'b1;
    wait_clks(half_clks);
    sda_drv <= 1'b1;
    wait_clks(half_clks);
  endtask

  task automatic send_byte(input logic [7:0] b, output logic ack);
    logic s;
    for (int i = 7; i >= 0; i--) begin
      clock_bit(b[i], s);
    end
    clock_bit(1'b1, s);
    ack = ~s;
  endtask

  // The master releases SDA for data and answers NACK on the last byte
  task automatic recv_byte(input logic last, output logic [7:0] b);
    logic s;
    for (int i = 7; i >= 0; i--) begin
      clock_bit(1'b1, s);
      b[i] = s;
    end
    clock_bit(last, s);
  endtask

  // Writes the bytes queued in wr_q from reg_addr on, then checks what changed
  task automatic write_regs(input logic [7:0] reg_addr);
    logic ack;
    send_start();
    send_byte({`OSD_I2C_DEV_ADDR, 1'b0}, ack);
    expect_ack(ack, "device address of a write");
    send_byte(reg_addr, ack);
    expect_ack(ack, "register address");
    addr_m = reg_addr;
    touched_q.delete();
    foreach (wr_q[i]) begin
      send_byte(wr_q[i], ack);
      expect_ack(ack, "write data byte");
      model_write(wr_q[i]);
    end
    send_stop();
    foreach (touched_q[i]) begin
      check_display(touched_q[i]);
    end
    check_ctrl(ctrl_m);
  endtask

  // Sets the register address, then reads n bytes after a repeated START
  task automatic read_regs(input logic [7:0] reg_addr, input int n);
    logic               ack;
    logic [7:0]         b;
    i2c_pkg::reg_resp_t got;
    i2c_pkg::reg_resp_t exp;
    send_start();
    send_byte({`OSD_I2C_DEV_ADDR, 1'b0}, ack);
    expect_ack(ack, "device address of a write");
    send_byte(reg_addr, ack);
    expect_ack(ack, "register address");
    send_start();
    send_byte({`OSD_I2C_DEV_ADDR, 1'b1}, ack);
    expect_ack(ack, "device address of a read");
    addr_m = reg_addr;
    for (int i = 0; i < n; i++) begin
      recv_byte(i == n - 1, b);
      got.rdata = b;
      exp.rdata = model_read();
      check_byte("read data", got, exp);
    end
    send_stop();
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    logic [7:0]             col;
    logic [6:0]             bad;
    logic                   ack;
    logic [`OSD_RAM_AW-1:0] ra;
    logic [`OSD_RAM_AW-1:0] nxt;
    int                     n;
    void'($urandom(32'hd53f_fc5c));
    rst_n     = 1'b0;
    scl       = 1'b1;
    sda_drv   = 1'b1;
    disp_addr = '0;
    ctrl_m    = '0;
    addr_m    = 8'd0;
    written   = '{default: 1'b0};
    wait_clks(16);
    rst_n <= 1'b1;
    wait_clks(4);

    // Random page, then a burst of random bytes at a random column
    repeat (4) begin
      wr_q.delete();
      wr_q.push_back(8'($urandom));
      write_regs(8'h80);
      col = 8'($urandom_range(0, 120));
      n   = $urandom_range(2, 8);
      wr_q.delete();
      repeat (n) wr_q.push_back(8'($urandom));
      write_regs(col);
    end

    // Auto-increment across the end of the window and across the 8-bit wrap
    wr_q.delete();
    repeat (4) wr_q.push_back(8'($urandom));
    write_regs(8'h7d);
    wr_q.delete();
    repeat (6) wr_q.push_back(8'($urandom));
    write_regs(8'hfe);

    // The enable follows bit 0, ending switched on
    for (int i = 0; i < 5; i++) begin
      wr_q.delete();
      wr_q.push_back({7'($urandom), ~i[0]});
      write_regs(8'h81);
    end

    // Register readback, then RAM readback through the page current at read time
    read_regs(8'h80, 2);
    repeat (6) begin
      ra = 10'($urandom);
      while (!written[ra]) begin
        ra = 10'($urandom);
      end
      wr_q.delete();
      wr_q.push_back({{(8 - `OSD_PAGE_W){1'b0}}, ra[`OSD_RAM_AW-1:7]});
      write_regs(8'h80);
      n   = 1;
      nxt = ra + 10'd1;
      while (n < 4 && nxt[6:0] != 7'd0 && written[nxt]) begin
        n++;
        nxt = nxt + 10'd1;
      end
      read_regs({1'b0, ra[6:0]}, n);
    end

    // A foreign device address must be ignored
    // The first transfer would flip the enable, the second would overwrite a cell of this page
    for (int i = 0; i < 2; i++) begin
      bad = 7'($urandom);
      if (bad == `OSD_I2C_DEV_ADDR) begin
        bad = bad ^ 7'h01;
      end
      send_start();
      send_byte({bad, 1'b0}, ack);
      if (ack) begin
        bus_errs++;
        $display("The DUT acknowledged foreign address %h at %0t", bad, $time);
      end
      send_byte((i == 0) ? 8'h81 : {1'b0, ra[6:0]}, ack);
      send_byte((i == 0) ? {7'd0, ~ctrl_m.enable} : ~mem_m[ra], ack);
      send_stop();
    end
    ra = '0;
    repeat (`OSD_RAM_DEPTH) begin
      if (written[ra]) begin
        check_display(ra);
      end
      ra = ra + 10'd1;
    end
    check_ctrl(ctrl_m);

    wait_clks(4);
    $display("Errors: data %0d, ctrl %0d, bus %0d", data_errs, ctrl_errs, bus_errs);
    if (data_errs + ctrl_errs + bus_errs == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
